// File: flist.f
source/isa_pkg.sv
source/core_pkg.sv
source/sync_ram.sv
source/fetcher.sv
source/decoder.sv
source/regs.sv
source/alu.sv
source/lsu.sv
source/cpu.sv
sim/tb_cpu.sv

// File: sim/tb_cpu.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu
    import core_pkg::*;
    import isa_pkg::*;
();

    localparam int PROG_LEN    = 27;
    localparam int EXP_LEN     = 18;
    localparam int CYCLE_LIMIT = PROG_LEN * 6 + 20;
    localparam int HALT_WATCH  = 10;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
    } wb_entry_t;

    // program image, one word per line
    localparam instr_t PROG [PROG_LEN] = '{
        {OP_LI,   4'd1,  8'h5A},          // 0  r1 = 0x5a
        {OP_LI,   4'd2,  8'hFD},          // 1  r2 = -3
        {OP_LI,   4'd0,  8'h07},          // 2  r0 write, dropped
        {OP_ADD,  4'd3,  4'd1,  4'd2},    // 3
        {OP_SUB,  4'd4,  4'd1,  4'd2},    // 4
        {OP_AND,  4'd5,  4'd1,  4'd2},    // 5
        {OP_OR,   4'd6,  4'd1,  4'd2},    // 6
        {OP_XOR,  4'd7,  4'd1,  4'd2},    // 7
        {OP_SLT,  4'd8,  4'd2,  4'd1},    // 8  -3 < 90
        {OP_SLT,  4'd9,  4'd1,  4'd2},    // 9  90 < -3
        {OP_LI,   4'd10, 8'h24},          // 10 shift amount 36, low bits give 4
        {OP_SLL,  4'd11, 4'd1,  4'd10},   // 11
        {OP_SRL,  4'd12, 4'd2,  4'd10},   // 12
        {OP_LI,   4'd13, 8'h45},          // 13 index 69 wraps to 5
        {OP_LI,   4'd14, 8'h05},          // 14
        {OP_ST,   4'd7,  4'd14, 4'd0},    // 15 mem[5] = r7
        {OP_LD,   4'd15, 4'd13, 4'd0},    // 16 r15 = mem[69 mod 64]
        {OP_BEQ,  4'd15, 4'd7,  4'd1},    // 17 r15 equals r7, taken, skips 18
        {OP_LI,   4'd1,  8'h11},          // 18 skipped
        {OP_BNE,  4'd9,  4'd0,  4'd1},    // 19 r9 and r0 both zero, not taken
        {OP_LI,   4'd2,  8'h22},          // 20
        {OP_JAL,  4'd9,  8'h02},          // 21 pc 42, jumps to 48
        {OP_LI,   4'd10, 8'h33},          // 22 skipped
        {OP_LI,   4'd11, 8'h44},          // 23 skipped
        {OP_LI,   4'd12, 8'h55},          // 24 jal target
        {OP_HALT, 12'h000},               // 25
        {OP_LI,   4'd13, 8'h66}           // 26 never reached
    };

    // writebacks in order, worked out by hand
    localparam wb_entry_t EXPECTED [EXP_LEN] = '{
        {4'd1,  32'h0000_005A},
        {4'd2,  32'hFFFF_FFFD},
        {4'd3,  32'h0000_0057},
        {4'd4,  32'h0000_005D},
        {4'd5,  32'h0000_0058},
        {4'd6,  32'hFFFF_FFFF},
        {4'd7,  32'hFFFF_FFA7},
        {4'd8,  32'h0000_0001},
        {4'd9,  32'h0000_0000},
        {4'd10, 32'h0000_0024},
        {4'd11, 32'h0000_05A0},
        {4'd12, 32'h0FFF_FFFF},
        {4'd13, 32'h0000_0045},
        {4'd14, 32'h0000_0005},
        {4'd15, 32'hFFFF_FFA7},
        {4'd2,  32'h0000_0022},
        {4'd9,  32'h0000_002C},
        {4'd12, 32'h0000_0055}
    };

    logic      clk;
    logic      rstn;
    logic      prog_we;
    pc_t       prog_addr;
    instr_t    prog_data;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;
    logic      halted;

    int errors;
    int wb_count;
    int cycles;
    bit timed_out;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    cpu dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .halted    (halted)
    );

    task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t exp, input int idx);
        if (got !== exp) begin
            $display("ERROR %0t: writeback %0d went to r%0d, expected r%0d",
                     $time, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_word(input word_t got, input word_t exp, input int idx);
        if (got !== exp) begin
            $display("ERROR %0t: writeback %0d data %h, expected %h", $time, idx, got, exp);
            errors++;
        end
    endtask

    // compare one writeback against the next table entry
    task automatic take_writeback();
        if (wb_count >= EXP_LEN) begin
            $display("unexpected extra writeback to r%0d with data %h", wb_addr, wb_data);
            errors++;
        end else begin
            check_reg_addr(wb_addr, EXPECTED[wb_count].addr, wb_count);
            check_word(wb_data, EXPECTED[wb_count].data, wb_count);
        end
        wb_count++;
    endtask

    initial begin
        rstn      = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        errors    = 0;
        wb_count  = 0;
        cycles    = 0;
        timed_out = 1'b0;

        // load the program while reset is held
        for (int i = 0; i < PROG_LEN; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = pc_t'(i);
            prog_data = PROG[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;

        // sample mid-cycle until halt or timeout
        while (!halted && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (wb_valid) begin
                take_writeback();
            end
            if (cycles >= CYCLE_LIMIT && !halted) begin
                $display("timeout: core did not halt within %0d cycles", CYCLE_LIMIT);
                timed_out = 1'b1;
                errors++;
            end
        end

        if (!timed_out) begin
            if (wb_count != EXP_LEN) begin
                $display("wrong number of writebacks before halt: saw %0d, expected %0d",
                         wb_count, EXP_LEN);
                errors++;
            end
            // halted must hold, nothing more gets written
            repeat (HALT_WATCH) begin
                @(negedge clk);
                if (wb_valid) begin
                    $display("writeback to r%0d seen after the core halted", wb_addr);
                    errors++;
                end
                if (!halted) begin
                    $display("halted went low again after the core halted");
                    errors++;
                end
            end
        end

        $display("errors: %0d, writebacks seen: %0d of %0d", errors, wb_count, EXP_LEN);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cpu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      prog_we,
    input  pc_t       prog_addr,
    input  instr_t    prog_data,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data,
    output logic      halted
);

    state_t    state;
    pc_t       pc;
    pc_t       pc_inc;
    logic      fetch_order;
    logic      fetched;
    instr_t    instr_f;
    instr_t    instr_q;

    reg_addr_t rs_a_addr;
    reg_addr_t rs_b_addr;
    word_t     rs_a_data;
    word_t     rs_b_data;
    logic      dec_is_alu;
    logic      dec_is_mem;
    logic      dec_is_store;
    logic      dec_is_branch;
    logic      dec_is_jump;
    logic      dec_is_subst;
    logic      dec_is_halt;
    alu_op_t   dec_alu_op;
    logic      dec_branch_ne;
    word_t     dec_opd_a;
    word_t     dec_opd_b;
    pc_t       dec_target;
    reg_addr_t dec_rd_addr;

    // decode stage registers
    logic      is_alu_q;
    logic      is_mem_q;
    logic      is_store_q;
    logic      is_branch_q;
    logic      is_jump_q;
    logic      is_subst_q;
    logic      is_halt_q;
    alu_op_t   alu_op_q;
    logic      branch_ne_q;
    word_t     opd_a_q;
    word_t     opd_b_q;
    pc_t       target_q;
    reg_addr_t rd_addr_q;

    // execute results
    word_t     alu_result;
    logic      branch_taken;
    logic      mem_req;
    logic      mem_done;
    word_t     mem_rdata;
    word_t     result_q;
    pc_t       next_pc_q;
    logic      write_q;
    logic      wr_en;

    assign pc_inc      = pc + 8'd2;
    assign fetch_order = (state == FETCH);
    assign mem_req     = (state == EXECUTE) && is_mem_q;
    assign wr_en       = (state == WRITE) && write_q;
    assign wb_valid    = wr_en && (rd_addr_q != '0);
    assign wb_addr     = rd_addr_q;
    assign wb_data     = result_q;
    assign halted      = (state == HALTED);

    fetcher fetch0 (
        .clk(clk), .rstn(rstn), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .pc(pc), .fetch_order(fetch_order),
        .instr(instr_f), .fetched(fetched)
    );

    decoder dec0 (
        .instr(instr_q), .pc(pc), .rs_a_addr(rs_a_addr), .rs_b_addr(rs_b_addr),
        .rs_a_data(rs_a_data), .rs_b_data(rs_b_data), .is_alu(dec_is_alu),
        .is_mem(dec_is_mem), .is_store(dec_is_store), .is_branch(dec_is_branch),
        .is_jump(dec_is_jump), .is_subst(dec_is_subst), .is_halt(dec_is_halt),
        .alu_op(dec_alu_op), .branch_ne(dec_branch_ne), .opd_a(dec_opd_a),
        .opd_b(dec_opd_b), .target(dec_target), .rd_addr(dec_rd_addr)
    );

    regs regs0 (
        .clk(clk), .rstn(rstn), .wr_en(wr_en), .wr_addr(rd_addr_q),
        .wr_data(result_q), .rd_addr_a(rs_a_addr), .rd_addr_b(rs_b_addr),
        .rd_data_a(rs_a_data), .rd_data_b(rs_b_data)
    );

    alu alu0 (
        .alu_op(alu_op_q), .branch_ne(branch_ne_q), .a(opd_a_q), .b(opd_b_q),
        .result(alu_result), .branch_taken(branch_taken)
    );

    lsu lsu0 (
        .clk(clk), .rstn(rstn), .mem_req(mem_req), .mem_write(is_store_q),
        .addr(opd_a_q), .wdata(opd_b_q), .rdata(mem_rdata), .mem_done(mem_done)
    );

    // control fsm
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state       <= FETCH;
            pc          <= '0;
            write_q     <= 1'b0;
            is_alu_q    <= 1'b0;
            is_mem_q    <= 1'b0;
            is_store_q  <= 1'b0;
            is_branch_q <= 1'b0;
            is_jump_q   <= 1'b0;
            is_subst_q  <= 1'b0;
            is_halt_q   <= 1'b0;
        end else begin
            case (state)
                FETCH: state <= FETCH_WAIT;
                FETCH_WAIT: begin
                    if (fetched) begin
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    is_alu_q    <= dec_is_alu;
                    is_mem_q    <= dec_is_mem;
                    is_store_q  <= dec_is_store;
                    is_branch_q <= dec_is_branch;
                    is_jump_q   <= dec_is_jump;
                    is_subst_q  <= dec_is_subst;
                    is_halt_q   <= dec_is_halt;
                    state       <= EXECUTE;
                end
                EXECUTE: begin
                    write_q <= is_alu_q || is_subst_q || is_jump_q || (is_mem_q && !is_store_q);
                    state   <= is_mem_q ? EXECUTE_WAIT : WRITE;
                end
                EXECUTE_WAIT: begin
                    if (mem_done) begin
                        state <= WRITE;
                    end
                end
                WRITE: begin
                    pc    <= next_pc_q;
                    state <= is_halt_q ? HALTED : FETCH;
                end
                HALTED: state <= HALTED;
                // illegal one-hot code
                default: state <= FETCH;
            endcase
        end
    end

    // datapath stage registers
    always_ff @(posedge clk) begin
        case (state)
            FETCH_WAIT: begin
                if (fetched) begin
                    instr_q <= instr_f;
                end
            end
            DECODE: begin
                alu_op_q    <= dec_alu_op;
                branch_ne_q <= dec_branch_ne;
                opd_a_q     <= dec_opd_a;
                opd_b_q     <= dec_opd_b;
                target_q    <= dec_target;
                rd_addr_q   <= dec_rd_addr;
            end
            EXECUTE: begin
                if (is_jump_q || (is_branch_q && branch_taken)) begin
                    next_pc_q <= target_q;
                end else begin
                    next_pc_q <= pc_inc;
                end
                if (is_alu_q) begin
                    result_q <= alu_result;
                end else if (is_jump_q) begin
                    result_q <= word_t'(pc_inc);
                end else begin
                    // li immediate
                    result_q <= opd_b_q;
                end
            end
            EXECUTE_WAIT: begin
                if (mem_done) begin
                    result_q <= mem_rdata;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/lsu.sv
`timescale 1ns/100ps
`default_nettype none

module lsu
    import core_pkg::*;
(
    input  logic  clk,
    input  logic  rstn,
    input  logic  mem_req,
    input  logic  mem_write,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata,
    output logic  mem_done
);

    dmem_addr_t index;
    logic       we;

    // word index wraps at DMEM_DEPTH
    assign index = addr[$bits(dmem_addr_t)-1:0];
    assign we    = mem_req && mem_write;

    sync_ram #(
        .elem_t (word_t),
        .DEPTH  (DMEM_DEPTH)
    ) dmem (
        .clk   (clk),
        .we    (we),
        .addr  (index),
        .wdata (wdata),
        .rdata (rdata)
    );

    // load data is valid in the done cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            mem_done <= 1'b0;
        end else begin
            mem_done <= mem_req;
        end
    end

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
    import core_pkg::*;
    import isa_pkg::*;
(
    input  alu_op_t alu_op,
    input  logic    branch_ne,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    branch_taken
);

    logic [4:0] shamt;
    logic       equal;

    // only low five bits shift
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLL: result = a << shamt;
            ALU_SRL: result = a >> shamt;
            default: result = '0;
        endcase
    end

    // beq/bne compare, kept apart from result
    assign equal        = (a == b);
    assign branch_taken = branch_ne ? !equal : equal;

endmodule

`default_nettype wire

// File: source/regs.sv
`timescale 1ns/100ps
`default_nettype none

module regs
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b
);

    word_t rf [NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            // r0 never written, so it stays zero
            rf[wr_addr] <= wr_data;
        end
    end

    assign rd_data_a = rf[rd_addr_a];
    assign rd_data_b = rf[rd_addr_b];

endmodule

`default_nettype wire

// File: source/decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder
    import core_pkg::*;
    import isa_pkg::*;
(
    input  instr_t    instr,
    input  pc_t       pc,
    output reg_addr_t rs_a_addr,
    output reg_addr_t rs_b_addr,
    input  word_t     rs_a_data,
    input  word_t     rs_b_data,
    output logic      is_alu,
    output logic      is_mem,
    output logic      is_store,
    output logic      is_branch,
    output logic      is_jump,
    output logic      is_subst,
    output logic      is_halt,
    output alu_op_t   alu_op,
    output logic      branch_ne,
    output word_t     opd_a,
    output word_t     opd_b,
    output pc_t       target,
    output reg_addr_t rd_addr
);

    opcode_t opcode;
    word_t   imm_word;
    pc_t     jump_off;
    pc_t     branch_off;

    assign opcode = opcode_t'(instr[OP_MSB:OP_LSB]);

    // instruction classes
    assign is_alu    = !instr[OP_MSB];
    assign is_subst  = (opcode == OP_LI);
    assign is_mem    = (opcode == OP_LD) || (opcode == OP_ST);
    assign is_store  = (opcode == OP_ST);
    assign is_branch = (opcode == OP_BEQ) || (opcode == OP_BNE);
    assign is_jump   = (opcode == OP_JAL);
    assign is_halt   = (opcode == OP_HALT);
    assign branch_ne = (opcode == OP_BNE);

    assign alu_op  = alu_op_t'(instr[OP_LSB+2:OP_LSB]);
    assign rd_addr = instr[RD_MSB:RD_LSB];

    // stores and branches need rd on the b port
    assign rs_a_addr = instr[RS1_MSB:RS1_LSB];
    assign rs_b_addr = (is_store || is_branch) ? instr[RD_MSB:RD_LSB]
                                               : instr[RS2_MSB:RS2_LSB];

    // li value goes out on opd_b
    assign imm_word = {{24{instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};
    assign opd_a    = rs_a_data;
    assign opd_b    = is_subst ? imm_word : rs_b_data;

    // offsets in halfwords, scaled to bytes
    assign jump_off   = {instr[IMM_MSB-1:IMM_LSB], 1'b0};
    assign branch_off = {{3{instr[OFF_MSB]}}, instr[OFF_MSB:OFF_LSB], 1'b0};
    assign target     = pc + 8'd2 + (is_jump ? jump_off : branch_off);

endmodule

`default_nettype wire

// File: source/fetcher.sv
`timescale 1ns/100ps
`default_nettype none

module fetcher
    import core_pkg::*;
    import isa_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   prog_we,
    input  pc_t    prog_addr,
    input  instr_t prog_data,
    input  pc_t    pc,
    input  logic   fetch_order,
    output instr_t instr,
    output logic   fetched
);

    logic [$clog2(IMEM_DEPTH)-1:0] ram_addr;

    // prog_addr is a word index, pc a byte address
    assign ram_addr = prog_we ? prog_addr[$clog2(IMEM_DEPTH)-1:0]
                              : pc[$clog2(IMEM_DEPTH):1];

    sync_ram #(
        .elem_t (instr_t),
        .DEPTH  (IMEM_DEPTH)
    ) imem (
        .clk   (clk),
        .we    (prog_we),
        .addr  (ram_addr),
        .wdata (prog_data),
        .rdata (instr)
    );

    // instruction word shows up together with fetched
    always_ff @(posedge clk) begin
        if (!rstn) begin
            fetched <= 1'b0;
        end else begin
            fetched <= fetch_order;
        end
    end

endmodule

`default_nettype wire

// File: source/sync_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sync_ram #(
    parameter type elem_t = logic [31:0],
    parameter int  DEPTH  = 64
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  elem_t                    wdata,
    output elem_t                    rdata
);

    elem_t mem [DEPTH];

    // write on the edge, registered read
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  pc_t;
    typedef logic [3:0]  reg_addr_t;
    typedef logic [5:0]  dmem_addr_t;

    // memory sizes in words
    localparam int IMEM_DEPTH = 128;
    localparam int DMEM_DEPTH = 64;
    localparam int NUM_REGS   = 16;

    // one-hot control states
    typedef enum logic [6:0] {
        FETCH        = 7'b0000001,
        FETCH_WAIT   = 7'b0000010,
        DECODE       = 7'b0000100,
        EXECUTE      = 7'b0001000,
        EXECUTE_WAIT = 7'b0010000,
        WRITE        = 7'b0100000,
        HALTED       = 7'b1000000
    } state_t;

endpackage

`default_nettype wire

// File: source/isa_pkg.sv
`default_nettype none

package isa_pkg;

    typedef logic [15:0] instr_t;

    // major opcode, top nibble of every instruction
    typedef enum logic [3:0] {
        OP_ADD  = 4'd0,
        OP_SUB  = 4'd1,
        OP_AND  = 4'd2,
        OP_OR   = 4'd3,
        OP_XOR  = 4'd4,
        OP_SLT  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_LI   = 4'd8,
        OP_LD   = 4'd9,
        OP_ST   = 4'd10,
        OP_BEQ  = 4'd11,
        OP_BNE  = 4'd12,
        OP_JAL  = 4'd13,
        OP_HALT = 4'd14,
        OP_NOP  = 4'd15
    } opcode_t;

    // alu function, same as the low three bits of opcodes 0..7
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_t;

    // instruction fields
    localparam int OP_MSB  = 15;
    localparam int OP_LSB  = 12;
    localparam int RD_MSB  = 11;
    localparam int RD_LSB  = 8;
    localparam int RS1_MSB = 7;
    localparam int RS1_LSB = 4;
    localparam int RS2_MSB = 3;
    localparam int RS2_LSB = 0;
    // branch offset shares bits with rs2
    localparam int OFF_MSB = 3;
    localparam int OFF_LSB = 0;
    // immediate of li and jal
    localparam int IMM_MSB = 7;
    localparam int IMM_LSB = 0;

endpackage

`default_nettype wire
